/* design/fifo_pkg.sv */
// Shared sizes and pointer conversions for the dual-clock FIFO
// Gray/binary helpers work on a fixed maximum width; callers zero-extend
`default_nettype none

package fifo_pkg;

    // --------------------
    // Default sizes
    // --------------------

    // 32-word deep buffer
    localparam int DEFAULT_ADDR_W       = 5;
    // One memory bus word
    localparam int DEFAULT_DATA_W       = 32;
    // Almost-empty asserts at or below this many words
    localparam int DEFAULT_AEMPTY_LEVEL = 10;
    // Widest pointer the helpers accept
    localparam int PTR_MAX_W            = 16;

    // --------------------
    // Pointer conversions
    // --------------------

    // Binary to Gray, adjacent values differ in one bit
    function automatic logic [PTR_MAX_W-1:0] bin2gray(input logic [PTR_MAX_W-1:0] bin);
        return (bin >> 1) ^ bin;
    endfunction

    // Gray to binary, running XOR from the top bit down
    function automatic logic [PTR_MAX_W-1:0] gray2bin(input logic [PTR_MAX_W-1:0] gray);
        logic [PTR_MAX_W-1:0] bin;
        bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
        for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
            bin[i] = gray[i] ^ bin[i+1];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

/* design/ptr_sync.sv */
// Two-flop synchronizer for a Gray-coded FIFO pointer
// Brings the other domain's pointer into the clk_i domain
`timescale 1ns/1ps
`default_nettype none

module ptr_sync
    import fifo_pkg::*;
#(
    // Pointer carries one extra wrap bit
    parameter int ADDR_W = DEFAULT_ADDR_W
) (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,
    // Pointer from the far domain
    input  wire logic [ADDR_W:0]   gray_i,
    // Same pointer, safe to use on clk_i
    output logic      [ADDR_W:0]   gray_o
);

    // First stage may go metastable
    logic [ADDR_W:0] gray_meta;

    // --------------------
    // Register chain
    // --------------------

    // Gray code changes one bit per step, so the captured value
    // is always either the old or the new pointer
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            gray_meta <= '0;
            gray_o    <= '0;
        end else begin
            gray_meta <= gray_i;
            // Second stage settles the first
            gray_o    <= gray_meta;
        end
    end

endmodule

`default_nettype wire

/* design/dual_clock_ram.sv */
// Simple dual-port RAM for the FIFO storage
// Write port on wclk_i, registered read address on rclk_i
`timescale 1ns/1ps
`default_nettype none

module dual_clock_ram
    import fifo_pkg::*;
#(
    parameter int ADDR_W = DEFAULT_ADDR_W,
    parameter int DATA_W = DEFAULT_DATA_W
) (
    // Write port
    input  wire logic                wclk_i,
    input  wire logic                we_i,
    input  wire logic [ADDR_W-1:0]   waddr_i,
    input  wire logic [DATA_W-1:0]   wdata_i,
    // Read port
    input  wire logic                rclk_i,
    input  wire logic                re_i,
    input  wire logic [ADDR_W-1:0]   raddr_i,
    output logic      [DATA_W-1:0]   rdata_o
);

    // Storage array
    logic [DATA_W-1:0] mem [2**ADDR_W];
    // Read address held for one read cycle
    logic [ADDR_W-1:0] raddr_q;

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge wclk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Address only moves on an accepted read
    always_ff @(posedge rclk_i) begin
        if (re_i) begin
            raddr_q <= raddr_i;
        end
    end

    // Word valid the cycle after the address is taken
    assign rdata_o = mem[raddr_q];

endmodule

`default_nettype wire

/* design/fifo_wr_ctrl.sv */
// Write-side FIFO control
// Keeps the write pointer, raises full and almost-full,
// and reports the fill level seen from the write clock
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ctrl
    import fifo_pkg::*;
#(
    parameter int ADDR_W      = DEFAULT_ADDR_W,
    // Almost-full at or above this many words
    parameter int AFULL_LEVEL = (2 ** ADDR_W) - 1
) (
    input  wire logic                wclk_i,
    input  wire logic                rstn_i,
    // Write request from the sender
    input  wire logic                wen_i,
    // Read pointer already synchronized to wclk_i
    input  wire logic [ADDR_W:0]     rptr_sync_i,
    // RAM write port
    output logic                     we_o,
    output logic      [ADDR_W-1:0]   waddr_o,
    // Write pointer toward the read domain
    output logic      [ADDR_W:0]     wptr_gray_o,
    // Status
    output logic                     wfull_o,
    output logic                     wafull_o,
    output logic      [ADDR_W:0]     wdata_count_o
);

    // Current and next write pointers
    logic [ADDR_W:0]    wbin;
    logic [ADDR_W:0]    wgray;
    logic [ADDR_W:0]    wbnext;
    logic [ADDR_W:0]    wgnext;
    // Full-width helper results
    logic [PTR_MAX_W-1:0] wgnext_ext;
    logic [PTR_MAX_W-1:0] rbin_ext;
    // Read pointer in binary, and as the full-compare pattern
    logic [ADDR_W:0]    rbin_sync;
    logic [ADDR_W:0]    rptr_full_cmp;
    // Words held, as seen here
    logic [ADDR_W:0]    wdiff;

    // --------------------
    // Next pointer
    // --------------------

    // Writes while full are dropped
    assign we_o    = wen_i & ~wfull_o;
    assign waddr_o = wbin[ADDR_W-1:0];

    assign wbnext     = wbin + (ADDR_W+1)'(we_o);
    assign wgnext_ext = bin2gray(PTR_MAX_W'(wbnext));
    assign wgnext     = wgnext_ext[ADDR_W:0];

    // --------------------
    // Read pointer compare
    // --------------------

    assign rbin_ext  = gray2bin(PTR_MAX_W'(rptr_sync_i));
    assign rbin_sync = rbin_ext[ADDR_W:0];

    // In Gray, one lap ahead means the top two bits flipped
    assign rptr_full_cmp = {~rptr_sync_i[ADDR_W -: 2], rptr_sync_i[ADDR_W-2:0]};

    // Wraps cleanly thanks to the extra pointer bit
    assign wdiff = wbin - rbin_sync;

    assign wptr_gray_o = wgray;

    // Pointer registers
    always_ff @(posedge wclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wbin  <= '0;
            wgray <= '0;
        end else begin
            wbin  <= wbnext;
            wgray <= wgnext;
        end
    end

    // --------------------
    // Flags and count
    // --------------------

    // Full goes high on the edge that takes the last free slot
    always_ff @(posedge wclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wfull_o       <= 1'b0;
            wafull_o      <= 1'b0;
            wdata_count_o <= '0;
        end else begin
            wfull_o       <= (wgnext == rptr_full_cmp);
            wafull_o      <= (wdiff >= (ADDR_W+1)'(AFULL_LEVEL));
            // One bit wider so a full FIFO reads as its depth
            wdata_count_o <= wdiff;
        end
    end

endmodule

`default_nettype wire

/* design/fifo_rd_ctrl.sv */
// Read-side FIFO control
// Keeps the read pointer, raises empty, almost-empty and half-empty,
// strobes accepted reads and reports the fill level seen from rclk_i
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ctrl
    import fifo_pkg::*;
#(
    parameter int ADDR_W       = DEFAULT_ADDR_W,
    // Almost-empty at or below this many words
    parameter int AEMPTY_LEVEL = DEFAULT_AEMPTY_LEVEL
) (
    input  wire logic                rclk_i,
    input  wire logic                rstn_i,
    // Read request from the consumer
    input  wire logic                ren_i,
    // Write pointer already synchronized to rclk_i
    input  wire logic [ADDR_W:0]     wptr_sync_i,
    // RAM read port
    output logic                     re_o,
    output logic      [ADDR_W-1:0]   raddr_o,
    // Read pointer toward the write domain
    output logic      [ADDR_W:0]     rptr_gray_o,
    // Read data valid, one cycle after the accepted read
    output logic                     rdata_rdy_o,
    // Status
    output logic                     rempty_o,
    output logic                     raempty_o,
    output logic                     rhempty_o,
    output logic      [ADDR_W:0]     rdata_count_o
);

    // Half the depth
    localparam int HEMPTY_LEVEL = (2 ** ADDR_W) / 2;

    // Current and next read pointers
    logic [ADDR_W:0]    rbin;
    logic [ADDR_W:0]    rgray;
    logic [ADDR_W:0]    rbnext;
    logic [ADDR_W:0]    rgnext;
    // Full-width helper results
    logic [PTR_MAX_W-1:0] rgnext_ext;
    logic [PTR_MAX_W-1:0] wbin_ext;
    // Write pointer in binary
    logic [ADDR_W:0]    wbin_sync;
    // Words held, as seen here
    logic [ADDR_W:0]    rdiff;

    // --------------------
    // Next pointer
    // --------------------

    // Reads while empty are dropped
    assign re_o    = ren_i & ~rempty_o;
    assign raddr_o = rbin[ADDR_W-1:0];

    assign rbnext     = rbin + (ADDR_W+1)'(re_o);
    assign rgnext_ext = bin2gray(PTR_MAX_W'(rbnext));
    assign rgnext     = rgnext_ext[ADDR_W:0];

    // --------------------
    // Fill level
    // --------------------

    assign wbin_ext  = gray2bin(PTR_MAX_W'(wptr_sync_i));
    assign wbin_sync = wbin_ext[ADDR_W:0];

    // Extra pointer bit keeps this right across wrap
    assign rdiff = wbin_sync - rbin;

    assign rptr_gray_o = rgray;

    // Pointer registers
    always_ff @(posedge rclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbnext;
            rgray <= rgnext;
        end
    end

    // --------------------
    // Read strobe
    // --------------------

    // Matches the RAM address register, so data lines up with it
    always_ff @(posedge rclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rdata_rdy_o <= 1'b0;
        end else begin
            rdata_rdy_o <= re_o;
        end
    end

    // --------------------
    // Flags and count
    // --------------------

    // Empty goes high on the edge that takes the last word
    always_ff @(posedge rclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rempty_o      <= 1'b1;
            raempty_o     <= 1'b1;
            rhempty_o     <= 1'b1;
            rdata_count_o <= '0;
        end else begin
            rempty_o      <= (rgnext == wptr_sync_i);
            raempty_o     <= (rdiff <= (ADDR_W+1)'(AEMPTY_LEVEL));
            rhempty_o     <= (rdiff <= (ADDR_W+1)'(HEMPTY_LEVEL));
            // Extra bit lets a full FIFO report its depth
            rdata_count_o <= rdiff;
        end
    end

endmodule

`default_nettype wire

/* design/async_fifo_top.sv */
// Dual-clock FIFO for video words between a memory bus and a pixel clock
// Gray pointers cross domains through two-flop synchronizers
`timescale 1ns/1ps
`default_nettype none

module async_fifo_top
    import fifo_pkg::*;
#(
    parameter int ADDR_W       = DEFAULT_ADDR_W,
    parameter int DATA_W       = DEFAULT_DATA_W,
    parameter int AEMPTY_LEVEL = DEFAULT_AEMPTY_LEVEL,
    // One below the depth by default
    parameter int AFULL_LEVEL  = (2 ** ADDR_W) - 1
) (
    // Shared asynchronous reset for both domains
    input  wire logic                rstn_i,
    // Write domain
    input  wire logic                wclk_i,
    input  wire logic                wen_i,
    input  wire logic [DATA_W-1:0]   wdata_i,
    output logic                     wfull_o,
    output logic                     wafull_o,
    output logic      [ADDR_W:0]     wdata_count_o,
    // Read domain
    input  wire logic                rclk_i,
    input  wire logic                ren_i,
    output logic      [DATA_W-1:0]   rdata_o,
    output logic                     rdata_rdy_o,
    output logic                     rempty_o,
    output logic                     raempty_o,
    output logic                     rhempty_o,
    output logic      [ADDR_W:0]     rdata_count_o
);

    // RAM write port
    logic                ram_we;
    logic [ADDR_W-1:0]   ram_waddr;
    // RAM read port
    logic                ram_re;
    logic [ADDR_W-1:0]   ram_raddr;
    // Pointers before and after crossing
    logic [ADDR_W:0]     wptr_gray;
    logic [ADDR_W:0]     wptr_sync;
    logic [ADDR_W:0]     rptr_gray;
    logic [ADDR_W:0]     rptr_sync;

    // --------------------
    // Write domain
    // --------------------
    fifo_wr_ctrl #(
        .ADDR_W      (ADDR_W),
        .AFULL_LEVEL (AFULL_LEVEL)
    ) wr_ctrl0 (
        .wclk_i        (wclk_i),
        .rstn_i        (rstn_i),
        .wen_i         (wen_i),
        .rptr_sync_i   (rptr_sync),
        .we_o          (ram_we),
        .waddr_o       (ram_waddr),
        .wptr_gray_o   (wptr_gray),
        .wfull_o       (wfull_o),
        .wafull_o      (wafull_o),
        .wdata_count_o (wdata_count_o)
    );

    // Read pointer into the write clock
    ptr_sync #(.ADDR_W(ADDR_W)) rptr_sync0 (
        .clk_i  (wclk_i),
        .rstn_i (rstn_i),
        .gray_i (rptr_gray),
        .gray_o (rptr_sync)
    );

    // --------------------
    // Read domain
    // --------------------
    fifo_rd_ctrl #(
        .ADDR_W       (ADDR_W),
        .AEMPTY_LEVEL (AEMPTY_LEVEL)
    ) rd_ctrl0 (
        .rclk_i        (rclk_i),
        .rstn_i        (rstn_i),
        .ren_i         (ren_i),
        .wptr_sync_i   (wptr_sync),
        .re_o          (ram_re),
        .raddr_o       (ram_raddr),
        .rptr_gray_o   (rptr_gray),
        .rdata_rdy_o   (rdata_rdy_o),
        .rempty_o      (rempty_o),
        .raempty_o     (raempty_o),
        .rhempty_o     (rhempty_o),
        .rdata_count_o (rdata_count_o)
    );

    // Write pointer into the read clock
    ptr_sync #(.ADDR_W(ADDR_W)) wptr_sync0 (
        .clk_i  (rclk_i),
        .rstn_i (rstn_i),
        .gray_i (wptr_gray),
        .gray_o (wptr_sync)
    );

    // --------------------
    // Storage
    // --------------------
    dual_clock_ram #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) ram0 (
        .wclk_i  (wclk_i),
        .we_i    (ram_we),
        .waddr_i (ram_waddr),
        .wdata_i (wdata_i),
        .rclk_i  (rclk_i),
        .re_i    (ram_re),
        .raddr_i (ram_raddr),
        .rdata_o (rdata_o)
    );

endmodule

`default_nettype wire

/* tests/tb_async_fifo.sv */
// Testbench for the dual-clock FIFO
// A queue model of accepted writes checks data order, flags and counts
// across reset, overflow, underflow, fill levels and mixed traffic
`timescale 1ns/1ps
`default_nettype none

module tb_async_fifo;

    localparam int ADDR_W         = 5;
    localparam int DATA_W         = 32;
    localparam int CNT_W          = ADDR_W + 1;
    localparam int DEPTH          = 2 ** ADDR_W;
    localparam int AEMPTY_LEVEL   = 10;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                rstn_i;
    logic                wclk_i;
    logic                wen_i;
    logic [DATA_W-1:0]   wdata_i;
    logic                rclk_i;
    logic                ren_i;
    logic                wfull_o;
    logic                wafull_o;
    logic [CNT_W-1:0]    wdata_count_o;
    logic [DATA_W-1:0]   rdata_o;
    logic                rdata_rdy_o;
    logic                rempty_o;
    logic                raempty_o;
    logic                rhempty_o;
    logic [CNT_W-1:0]    rdata_count_o;

    // Reference model with the oldest word at the front
    logic [DATA_W-1:0]   model_q[$];
    integer              seed;
    logic [31:0]         wrnd;
    logic [31:0]         rrnd;
    int                  errors;
    int                  data_errors;
    int                  rd_pulses;
    int                  cycles;

    async_fifo_top dut0 (
        .rstn_i        (rstn_i),
        .wclk_i        (wclk_i),
        .wen_i         (wen_i),
        .wdata_i       (wdata_i),
        .wfull_o       (wfull_o),
        .wafull_o      (wafull_o),
        .wdata_count_o (wdata_count_o),
        .rclk_i        (rclk_i),
        .ren_i         (ren_i),
        .rdata_o       (rdata_o),
        .rdata_rdy_o   (rdata_rdy_o),
        .rempty_o      (rempty_o),
        .raempty_o     (raempty_o),
        .rhempty_o     (rhempty_o),
        .rdata_count_o (rdata_count_o)
    );

    // --------------------
    // Clocks and timeout
    // --------------------

    // Pixel side at 4 ns
    initial begin
        rclk_i = 1'b0;
        forever #2 rclk_i = ~rclk_i;
    end

    // Memory bus side at 6 ns with rising edges that never meet rclk_i rising edges
    initial begin
        wclk_i = 1'b0;
        forever #3 wclk_i = ~wclk_i;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge rclk_i);
            cycles = cycles + 1;
        end
        $display("Timeout: run did not finish within %0d read clock cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // --------------------
    // Reference functions
    // --------------------

    // Oldest accepted word still in the FIFO
    function automatic logic [DATA_W-1:0] expected_word();
        return model_q[0];
    endfunction

    // Flags for fill level k packed as {rempty, raempty, rhempty, wafull, wfull}
    function automatic logic [4:0] expected_flags(input int k);
        logic [4:0] f;
        f[4] = (k == 0);
        f[3] = (k <= AEMPTY_LEVEL);
        f[2] = (k <= DEPTH / 2);
        // Almost-full level defaults to depth minus one
        f[1] = (k >= DEPTH - 1);
        f[0] = (k == DEPTH);
        return f;
    endfunction

    // Compare every strobed word at mid-cycle where it is stable
    always @(negedge rclk_i) begin
        if (rdata_rdy_o) begin
            rd_pulses = rd_pulses + 1;
            if (model_q.size() == 0) begin
                $display("Read strobe at %0t with no word left in the model", $time);
                data_errors = data_errors + 1;
            end else begin
                if (rdata_o !== expected_word()) begin
                    $display("FAIL rdata_o: expected %h, got %h", expected_word(), rdata_o);
                    data_errors = data_errors + 1;
                end
                void'(model_q.pop_front());
            end
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    // Push n random words and keep in the model only those that wfull_o lets in
    task write_words(input int n);
        repeat (n) begin
            @(posedge wclk_i);
            #1;
            wen_i   = 1'b1;
            wdata_i = $random(seed);
            if (!wfull_o) begin
                model_q.push_back(wdata_i);
            end
        end
        @(posedge wclk_i);
        #1;
        wen_i = 1'b0;
    endtask

    // Both sides idle long enough for pointers to cross, then sample
    task wait_settle();
        repeat (8) @(posedge wclk_i);
        @(negedge rclk_i);
    endtask

    task check_level(input int k);
        logic [4:0] exp_f;
        logic [4:0] got_f;
        exp_f = expected_flags(k);
        got_f = {rempty_o, raempty_o, rhempty_o, wafull_o, wfull_o};
        if (got_f !== exp_f) begin
            $display("FAIL {rempty_o,raempty_o,rhempty_o,wafull_o,wfull_o}: expected %h, got %h",
                     exp_f, got_f);
            errors = errors + 1;
        end
        if (wdata_count_o !== CNT_W'(k)) begin
            $display("FAIL wdata_count_o: expected %h, got %h", CNT_W'(k), wdata_count_o);
            errors = errors + 1;
        end
        if (rdata_count_o !== CNT_W'(k)) begin
            $display("FAIL rdata_count_o: expected %h, got %h", CNT_W'(k), rdata_count_o);
            errors = errors + 1;
        end
    endtask

    // Hold ren_i until empty, then check every queued word came out
    task drain_fifo();
        int n_exp;
        int base;
        n_exp = model_q.size();
        base  = rd_pulses;
        @(posedge rclk_i);
        #1;
        ren_i = 1'b1;
        while (!rempty_o) begin
            @(posedge rclk_i);
            #1;
        end
        ren_i = 1'b0;
        repeat (3) @(posedge rclk_i);
        if (rd_pulses - base != n_exp) begin
            $display("Drain gave %0d read strobes, %0d words were written",
                     rd_pulses - base, n_exp);
            errors = errors + 1;
        end
    endtask

    // Reads on an empty FIFO must be ignored
    task check_underflow();
        @(posedge rclk_i);
        #1;
        ren_i = 1'b1;
        repeat (10) begin
            @(negedge rclk_i);
            if (rdata_rdy_o !== 1'b0) begin
                $display("FAIL rdata_rdy_o: expected %h, got %h", 1'b0, rdata_rdy_o);
                errors = errors + 1;
            end
            if (rempty_o !== 1'b1) begin
                $display("FAIL rempty_o: expected %h, got %h", 1'b1, rempty_o);
                errors = errors + 1;
            end
            if (rdata_count_o !== CNT_W'(0)) begin
                $display("FAIL rdata_count_o: expected %h, got %h", CNT_W'(0), rdata_count_o);
                errors = errors + 1;
            end
        end
        @(posedge rclk_i);
        #1;
        ren_i = 1'b0;
    endtask

    task fill_to_level(input int k);
        write_words(k - model_q.size());
        wait_settle();
        check_level(k);
    endtask

    // Random writes and reads on both clocks at once
    task run_traffic(input int n);
        fork
            begin
                repeat (n) begin
                    @(posedge wclk_i);
                    #1;
                    wrnd    = $random(seed);
                    // Writes lean ahead so the FIFO fills now and then
                    wen_i   = (wrnd[1:0] != 2'b00);
                    wdata_i = $random(seed);
                    if (wen_i && !wfull_o) begin
                        model_q.push_back(wdata_i);
                    end
                end
                @(posedge wclk_i);
                #1;
                wen_i = 1'b0;
            end
            begin
                repeat (n) begin
                    @(posedge rclk_i);
                    #1;
                    rrnd  = $random(seed);
                    ren_i = rrnd[0];
                end
                @(posedge rclk_i);
                #1;
                ren_i = 1'b0;
            end
        join
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rstn_i      = 1'b0;
        wen_i       = 1'b0;
        wdata_i     = '0;
        ren_i       = 1'b0;
        seed        = 89270;
        errors      = 0;
        data_errors = 0;
        rd_pulses   = 0;

        repeat (3) @(posedge rclk_i);
        #1;
        rstn_i = 1'b1;

        // Reset state
        wait_settle();
        check_level(0);
        if (rdata_rdy_o !== 1'b0) begin
            $display("FAIL rdata_rdy_o: expected %h, got %h", 1'b0, rdata_rdy_o);
            errors = errors + 1;
        end

        // Ordering
        write_words(20);
        wait_settle();
        check_level(20);
        drain_fifo();

        // Overflow keeps only the first DEPTH words
        write_words(35);
        wait_settle();
        if (model_q.size() != DEPTH) begin
            $display("Overflow kept %0d words in the model instead of %0d",
                     model_q.size(), DEPTH);
            errors = errors + 1;
        end
        check_level(DEPTH);
        drain_fifo();

        check_underflow();

        // Flag thresholds on both sides
        fill_to_level(5);
        fill_to_level(10);
        fill_to_level(11);
        fill_to_level(16);
        fill_to_level(17);
        fill_to_level(30);
        fill_to_level(31);
        drain_fifo();

        run_traffic(200);
        wait_settle();
        check_level(model_q.size());
        drain_fifo();

        $display("Run complete: %0d check errors, %0d data errors", errors, data_errors);
        if (errors + data_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/fifo_pkg.sv
design/ptr_sync.sv
design/dual_clock_ram.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/async_fifo_top.sv
tests/tb_async_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dual-clock FIFO testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_async_fifo

verilator --binary --timing -f filelist.f --top-module tb_async_fifo -o tb_async_fifo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** FAILED ***" "$LOG"; then
    exit 1
fi
if ! grep -qF "*** PASSED ***" "$LOG"; then
    echo "Simulation log holds no final result"
    exit 1
fi
exit 0
